//--- source/mini_mips_cfg.svh
`ifndef MINI_MIPS_CFG_SVH
`define MINI_MIPS_CFG_SVH

// data word width
`define MM_XLEN 32

// architectural register count
`define MM_REG_COUNT 32

// register index width
`define MM_REG_ADDR_W 5

// clock edges from issue strobe to retire strobe
// decode, execute, memory, write-back
`define MM_RETIRE_LATENCY 4

`endif

//--- source/mini_mips_pkg.sv
package mini_mips_pkg;

  `include "mini_mips_cfg.svh"

  // primary opcode field
  typedef enum logic [5:0] {
    OP_RTYPE = 6'd0,
    OP_ADDI  = 6'd8
  } opcode_e;

  // r-type function field
  typedef enum logic [5:0] {
    FN_ADD = 6'd32,
    FN_SUB = 6'd34,
    FN_AND = 6'd36,
    FN_OR  = 6'd37,
    FN_XOR = 6'd38,
    FN_SLT = 6'd42
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  typedef struct packed {
    logic    write_reg;
    logic    use_imm;
    alu_op_e alu_op;
  } control_t;

  typedef struct packed {
    opcode_e                    opcode;
    logic [`MM_REG_ADDR_W-1:0] rs;
    logic [`MM_REG_ADDR_W-1:0] rt;
    logic [`MM_REG_ADDR_W-1:0] rd;
    funct_e                     funct;
    logic [15:0]                imm;
    logic [`MM_REG_ADDR_W-1:0] dest;
    control_t                   control;
  } unpack_t;

  // one pipeline stage
  typedef struct packed {
    logic                       valid;
    logic [`MM_XLEN-1:0]        instruction;
    control_t                   control;
    logic [`MM_REG_ADDR_W-1:0] dest_reg;
    logic [`MM_XLEN-1:0]        dest_reg_data;
    logic [`MM_XLEN-1:0]        rs_data;
    logic [`MM_XLEN-1:0]        rt_data;
  } pipeline_signal_t;

  typedef struct packed {
    logic                forward_rs;
    logic                forward_rt;
    logic [`MM_XLEN-1:0] rs;
    logic [`MM_XLEN-1:0] rt;
  } forward_info_t;

  typedef struct packed {
    logic                valid;
    logic [`MM_XLEN-1:0] instruction;
  } issue_t;

  typedef struct packed {
    logic                       valid;
    logic                       write;
    logic [`MM_REG_ADDR_W-1:0] dest;
    logic [`MM_XLEN-1:0]        data;
  } retire_t;

endpackage

//--- source/extract_instruction.sv
`timescale 1ns/1ps

`include "mini_mips_cfg.svh"

module extract_instruction import mini_mips_pkg::*; (
  input  logic [`MM_XLEN-1:0] instruction,
  output unpack_t             ei
);

  always_comb begin
    ei        = '0;
    // fixed mips field positions
    ei.opcode = opcode_e'(instruction[31:26]);
    ei.rs     = instruction[25:21];
    ei.rt     = instruction[20:16];
    ei.rd     = instruction[15:11];
    ei.funct  = funct_e'(instruction[5:0]);
    ei.imm    = instruction[15:0];

    ei.dest              = ei.rd;
    ei.control.write_reg = 1'b0;
    ei.control.use_imm   = 1'b0;
    ei.control.alu_op    = ALU_ADD;

    case (ei.opcode)
      OP_RTYPE: begin
        ei.control.write_reg = 1'b1;
        case (ei.funct)
          FN_ADD: ei.control.alu_op = ALU_ADD;
          FN_SUB: ei.control.alu_op = ALU_SUB;
          FN_AND: ei.control.alu_op = ALU_AND;
          FN_OR:  ei.control.alu_op = ALU_OR;
          FN_XOR: ei.control.alu_op = ALU_XOR;
          FN_SLT: ei.control.alu_op = ALU_SLT;
          // unknown funct retires as a no-op
          default: ei.control.write_reg = 1'b0;
        endcase
      end
      OP_ADDI: begin
        // i-type writes rt
        ei.dest              = ei.rt;
        ei.control.write_reg = 1'b1;
        ei.control.use_imm   = 1'b1;
        ei.control.alu_op    = ALU_ADD;
      end
      default: begin
        ei.control.write_reg = 1'b0;
      end
    endcase
  end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps

`include "mini_mips_cfg.svh"

module register_file (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`MM_REG_ADDR_W-1:0] rs_addr,
  input  logic [`MM_REG_ADDR_W-1:0] rt_addr,
  output logic [`MM_XLEN-1:0]        rs_data,
  output logic [`MM_XLEN-1:0]        rt_data,
  input  logic                       wr_en,
  input  logic [`MM_REG_ADDR_W-1:0] wr_addr,
  input  logic [`MM_XLEN-1:0]        wr_data
);

  logic [`MM_XLEN-1:0] regs [`MM_REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MM_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // register 0 reads as zero
  assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- source/main_forwarder.sv
`timescale 1ns/1ps

`include "mini_mips_cfg.svh"

module main_forwarder import mini_mips_pkg::*; (
  input  pipeline_signal_t ps_decode,
  input  pipeline_signal_t ps_execute,
  input  pipeline_signal_t ps_memory,
  input  pipeline_signal_t ps_write_back,
  output forward_info_t    decode_forward_info,
  output forward_info_t    execute_forward_info
);

  unpack_t execute_unpack;
  unpack_t decode_unpack;

  // true when a stage will write the register a consumer reads
  function automatic logic produces(input pipeline_signal_t         ps,
                                    input logic [`MM_REG_ADDR_W-1:0] src);
    return ps.valid && ps.control.write_reg && (ps.dest_reg != '0) &&
           (ps.dest_reg == src);
  endfunction

  extract_instruction execute_ei (
    .instruction(ps_execute.instruction),
    .ei         (execute_unpack)
  );

  extract_instruction decode_ei (
    .instruction(ps_decode.instruction),
    .ei         (decode_unpack)
  );

  // memory stage wins over write-back for execute operands
  always_comb begin
    execute_forward_info = '0;

    if (produces(ps_memory, execute_unpack.rs)) begin
      execute_forward_info.forward_rs = 1'b1;
      execute_forward_info.rs         = ps_memory.dest_reg_data;
    end else if (produces(ps_write_back, execute_unpack.rs)) begin
      execute_forward_info.forward_rs = 1'b1;
      execute_forward_info.rs         = ps_write_back.dest_reg_data;
    end

    if (produces(ps_memory, execute_unpack.rt)) begin
      execute_forward_info.forward_rt = 1'b1;
      execute_forward_info.rt         = ps_memory.dest_reg_data;
    end else if (produces(ps_write_back, execute_unpack.rt)) begin
      execute_forward_info.forward_rt = 1'b1;
      execute_forward_info.rt         = ps_write_back.dest_reg_data;
    end
  end

  // decode reads race the register file write in the same cycle
  always_comb begin
    decode_forward_info = '0;

    if (produces(ps_write_back, decode_unpack.rs)) begin
      decode_forward_info.forward_rs = 1'b1;
      decode_forward_info.rs         = ps_write_back.dest_reg_data;
    end

    if (produces(ps_write_back, decode_unpack.rt)) begin
      decode_forward_info.forward_rt = 1'b1;
      decode_forward_info.rt         = ps_write_back.dest_reg_data;
    end
  end

endmodule

//--- source/pipeline_datapath.sv
`timescale 1ns/1ps

`include "mini_mips_cfg.svh"

module pipeline_datapath import mini_mips_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  issue_t                     issue,
  output pipeline_signal_t           ps_decode,
  output pipeline_signal_t           ps_execute,
  output pipeline_signal_t           ps_memory,
  output pipeline_signal_t           ps_write_back,
  input  forward_info_t              decode_forward_info,
  input  forward_info_t              execute_forward_info,
  output logic [`MM_REG_ADDR_W-1:0] rs_addr,
  output logic [`MM_REG_ADDR_W-1:0] rt_addr,
  input  logic [`MM_XLEN-1:0]        rs_data,
  input  logic [`MM_XLEN-1:0]        rt_data,
  output logic                       wr_en,
  output logic [`MM_REG_ADDR_W-1:0] wr_addr,
  output logic [`MM_XLEN-1:0]        wr_data,
  output retire_t                    retire
);

  issue_t              decode_q;
  unpack_t             decode_fields;
  pipeline_signal_t    execute_next;
  pipeline_signal_t    memory_next;

  logic [`MM_XLEN-1:0] op_a;
  logic [`MM_XLEN-1:0] op_b_reg;
  logic [`MM_XLEN-1:0] op_b;
  logic [`MM_XLEN-1:0] imm_ext;
  logic [`MM_XLEN-1:0] alu_result;
  logic                wb_writes;

  // decode stage
  always_ff @(posedge clk) begin
    decode_q <= issue;
    if (rst) begin
      decode_q.valid <= 1'b0;
    end
  end

  extract_instruction decode_ei (
    .instruction(decode_q.instruction),
    .ei         (decode_fields)
  );

  assign rs_addr = decode_fields.rs;
  assign rt_addr = decode_fields.rt;

  always_comb begin
    ps_decode             = '0;
    ps_decode.valid       = decode_q.valid;
    ps_decode.instruction = decode_q.instruction;
    ps_decode.control     = decode_fields.control;
    ps_decode.dest_reg    = decode_fields.dest;
    ps_decode.rs_data     = rs_data;
    ps_decode.rt_data     = rt_data;
  end

  // bypass a same-cycle write-back into the captured operands
  always_comb begin
    execute_next = ps_decode;
    if (decode_forward_info.forward_rs) begin
      execute_next.rs_data = decode_forward_info.rs;
    end
    if (decode_forward_info.forward_rt) begin
      execute_next.rt_data = decode_forward_info.rt;
    end
  end

  // execute stage operand selection
  assign op_a     = execute_forward_info.forward_rs ? execute_forward_info.rs
                                                    : ps_execute.rs_data;
  assign op_b_reg = execute_forward_info.forward_rt ? execute_forward_info.rt
                                                    : ps_execute.rt_data;
  assign imm_ext  = {{(`MM_XLEN-16){ps_execute.instruction[15]}},
                     ps_execute.instruction[15:0]};
  assign op_b     = ps_execute.control.use_imm ? imm_ext : op_b_reg;

  always_comb begin
    case (ps_execute.control.alu_op)
      ALU_ADD: alu_result = op_a + op_b;
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_XOR: alu_result = op_a ^ op_b;
      // signed compare
      ALU_SLT: alu_result = {{(`MM_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_result = '0;
    endcase
  end

  always_comb begin
    memory_next               = ps_execute;
    memory_next.dest_reg_data = alu_result;
  end

  // execute, memory and write-back registers
  always_ff @(posedge clk) begin
    ps_execute    <= execute_next;
    ps_memory     <= memory_next;
    ps_write_back <= ps_memory;
    if (rst) begin
      ps_execute.valid    <= 1'b0;
      ps_memory.valid     <= 1'b0;
      ps_write_back.valid <= 1'b0;
    end
  end

  // write-back never writes register 0
  assign wb_writes = ps_write_back.valid && ps_write_back.control.write_reg &&
                     (ps_write_back.dest_reg != '0);

  assign wr_en   = wb_writes;
  assign wr_addr = ps_write_back.dest_reg;
  assign wr_data = ps_write_back.dest_reg_data;

  always_comb begin
    retire.valid = ps_write_back.valid;
    retire.write = wb_writes;
    retire.dest  = ps_write_back.dest_reg;
    retire.data  = wb_writes ? ps_write_back.dest_reg_data : '0;
  end

endmodule

//--- source/mini_mips_top.sv
`timescale 1ns/1ps

`include "mini_mips_cfg.svh"

module mini_mips_top import mini_mips_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  issue_t  issue,
  output retire_t retire
);

  pipeline_signal_t ps_decode;
  pipeline_signal_t ps_execute;
  pipeline_signal_t ps_memory;
  pipeline_signal_t ps_write_back;
  forward_info_t    decode_forward_info;
  forward_info_t    execute_forward_info;

  logic [`MM_REG_ADDR_W-1:0] rs_addr;
  logic [`MM_REG_ADDR_W-1:0] rt_addr;
  logic [`MM_XLEN-1:0]        rs_data;
  logic [`MM_XLEN-1:0]        rt_data;
  logic                       wr_en;
  logic [`MM_REG_ADDR_W-1:0] wr_addr;
  logic [`MM_XLEN-1:0]        wr_data;

  pipeline_datapath i_datapath (
    .clk                 (clk),
    .rst                 (rst),
    .issue               (issue),
    .ps_decode           (ps_decode),
    .ps_execute          (ps_execute),
    .ps_memory           (ps_memory),
    .ps_write_back       (ps_write_back),
    .decode_forward_info (decode_forward_info),
    .execute_forward_info(execute_forward_info),
    .rs_addr             (rs_addr),
    .rt_addr             (rt_addr),
    .rs_data             (rs_data),
    .rt_data             (rt_data),
    .wr_en               (wr_en),
    .wr_addr             (wr_addr),
    .wr_data             (wr_data),
    .retire              (retire)
  );

  // hazard bypass for execute and decode
  main_forwarder i_forwarder (
    .ps_decode           (ps_decode),
    .ps_execute          (ps_execute),
    .ps_memory           (ps_memory),
    .ps_write_back       (ps_write_back),
    .decode_forward_info (decode_forward_info),
    .execute_forward_info(execute_forward_info)
  );

  register_file i_register_file (
    .clk    (clk),
    .rst    (rst),
    .rs_addr(rs_addr),
    .rt_addr(rt_addr),
    .rs_data(rs_data),
    .rt_data(rt_data),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data)
  );

endmodule

//--- tests/mini_mips_sva.sv
`timescale 1ns/1ps

`include "mini_mips_cfg.svh"

module mini_mips_sva import mini_mips_pkg::*; (
  input logic    clk,
  input logic    rst,
  input issue_t  issue,
  input retire_t retire
);

  // pipeline empty on the first cycle out of reset
  a_quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !retire.valid)
    else $error("retire strobe in the first cycle after reset");

  // fixed issue to retire latency since nothing stalls
  a_retire_latency: assert property (@(posedge clk) disable iff (rst)
    issue.valid |-> ##(`MM_RETIRE_LATENCY) retire.valid)
    else $error("issued instruction did not retire after the fixed latency");

  a_reg_zero_no_write: assert property (@(posedge clk) disable iff (rst)
    (retire.valid && retire.dest == '0) |-> !retire.write)
    else $error("retire reports a write to register 0");

endmodule

bind mini_mips_top mini_mips_sva i_sva (
  .clk   (clk),
  .rst   (rst),
  .issue (issue),
  .retire(retire)
);

//--- tests/mini_mips_tb.sv
`timescale 1ns/1ps

`include "mini_mips_cfg.svh"

module mini_mips_tb import mini_mips_pkg::*; ();

  logic    clk;
  logic    rst;
  issue_t  issue;
  retire_t retire;

  integer              seed;
  int                  mismatch_count = 0;
  int                  other_count = 0;
  logic [`MM_XLEN-1:0] model_regs [`MM_REG_COUNT];
  retire_t             exp_q [$];
  string               name_q [$];

  mini_mips_top i_dut (
    .clk   (clk),
    .rst   (rst),
    .issue (issue),
    .retire(retire)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rtype(input logic [5:0]                funct,
                                        input logic [`MM_REG_ADDR_W-1:0] rd,
                                        input logic [`MM_REG_ADDR_W-1:0] rs,
                                        input logic [`MM_REG_ADDR_W-1:0] rt);
    return {6'd0, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] addi(input logic [`MM_REG_ADDR_W-1:0] rt,
                                       input logic [`MM_REG_ADDR_W-1:0] rs,
                                       input logic [15:0]               imm);
    return {6'd8, rs, rt, imm};
  endfunction

  // reference model runs each instruction at issue time
  task automatic model_execute(input logic [31:0] instr, output retire_t exp);
    logic [5:0]                opcode;
    logic [5:0]                funct;
    logic [`MM_XLEN-1:0]       a;
    logic [`MM_XLEN-1:0]       b;
    logic [`MM_XLEN-1:0]       imm;
    logic [`MM_XLEN-1:0]       result;
    logic [`MM_REG_ADDR_W-1:0] dest;
    logic                      writes;
    opcode = instr[31:26];
    funct  = instr[5:0];
    a      = model_regs[instr[25:21]];
    b      = model_regs[instr[20:16]];
    imm    = {{(`MM_XLEN-16){instr[15]}}, instr[15:0]};
    dest   = instr[15:11];
    writes = 1'b1;
    result = '0;
    if (opcode == 6'd0) begin
      case (funct)
        6'd32:   result = a + b;
        6'd34:   result = a - b;
        6'd36:   result = a & b;
        6'd37:   result = a | b;
        6'd38:   result = a ^ b;
        6'd42:   result = {{(`MM_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
        default: writes = 1'b0;
      endcase
    end else if (opcode == 6'd8) begin
      // addi targets rt
      dest   = instr[20:16];
      result = a + imm;
    end else begin
      writes = 1'b0;
    end
    exp.valid = 1'b1;
    exp.write = writes && (dest != '0);
    exp.dest  = dest;
    exp.data  = exp.write ? result : '0;
    if (exp.write) begin
      model_regs[dest] = result;
    end
  endtask

  task automatic check_retire(input string name, input retire_t expected,
                              input retire_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display(
        "Mismatch in %s: expected write=%0b dest=%0d data=%h, actual write=%0b dest=%0d data=%h",
        name, expected.write, expected.dest, expected.data,
        actual.write, actual.dest, actual.data);
    end
  endtask

  task automatic send(input logic [31:0] instr, input string name);
    retire_t exp;
    model_execute(instr, exp);
    exp_q.push_back(exp);
    name_q.push_back(name);
    issue.valid       = 1'b1;
    issue.instruction = instr;
    @(posedge clk);
    #1;
    issue.valid = 1'b0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  // only registers 0 to 7 so hazards come up often
  function automatic logic [31:0] random_instr();
    logic [31:0]               r;
    logic [31:0]               instr;
    logic [`MM_REG_ADDR_W-1:0] rs;
    logic [`MM_REG_ADDR_W-1:0] rt;
    logic [`MM_REG_ADDR_W-1:0] rd;
    logic [5:0]                op;
    r  = $random(seed);
    rs = {2'b00, r[2:0]};
    rt = {2'b00, r[5:3]};
    rd = {2'b00, r[8:6]};
    case (r[11:9])
      3'd0: instr = rtype(FN_ADD, rd, rs, rt);
      3'd1: instr = rtype(FN_SUB, rd, rs, rt);
      3'd2: instr = rtype(FN_AND, rd, rs, rt);
      3'd3: instr = rtype(FN_OR, rd, rs, rt);
      3'd4: instr = rtype(FN_XOR, rd, rs, rt);
      3'd5: instr = rtype(FN_SLT, rd, rs, rt);
      3'd6: instr = addi(rt, rs, r[31:16]);
      default: begin
        op = r[31:26];
        if (op == 6'd0 || op == 6'd8) begin
          op = 6'h3f;
        end
        // unknown opcode or unknown r-type funct
        instr = r[12] ? {op, rs, rt, r[15:0]} : rtype(6'd0, rd, rs, rt);
      end
    endcase
    return instr;
  endfunction

  // retire sampled mid-cycle
  always @(negedge clk) begin
    retire_t exp;
    string   name;
    if (retire.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        other_count++;
        $display("Error: retire strobe for dest %0d with no instruction outstanding",
                 retire.dest);
      end else begin
        exp  = exp_q.pop_front();
        name = name_q.pop_front();
        check_retire(name, exp, retire);
      end
    end
  end

  initial begin
    logic [31:0] r;
    int          drain;
    seed  = 32'h2f4a;
    rst   = 1'b1;
    // a live instruction held through reset must never retire
    issue.valid       = 1'b1;
    issue.instruction = addi(5'd1, 5'd0, 16'h1234);
    for (int i = 0; i < `MM_REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst   = 1'b0;
    issue = '0;

    // quiet pipeline then every register read through an add with r0
    idle(8);
    for (int i = 0; i < `MM_REG_COUNT; i++) begin
      send(rtype(FN_ADD, i[4:0], i[4:0], 5'd0), "reset_reads");
    end

    // back-to-back chain forwards memory to execute
    send(addi(5'd1, 5'd0, 16'h0013), "forward_mem");
    send(rtype(FN_ADD, 5'd1, 5'd1, 5'd1), "forward_mem");
    send(addi(5'd2, 5'd1, 16'hfff0), "forward_mem");
    send(rtype(FN_SUB, 5'd3, 5'd2, 5'd1), "forward_mem");
    send(rtype(FN_XOR, 5'd3, 5'd3, 5'd2), "forward_mem");
    send(rtype(FN_SLT, 5'd4, 5'd3, 5'd2), "forward_mem");
    send(rtype(FN_OR, 5'd4, 5'd4, 5'd3), "forward_mem");
    send(rtype(FN_AND, 5'd5, 5'd4, 5'd4), "forward_mem");

    // consumer one to four issues behind its producer
    for (int gap = 0; gap <= 3; gap++) begin
      send(addi(5'd6, 5'd6, 16'h0101), "forward_wb");
      idle(gap);
      send(rtype(FN_ADD, 5'd7, 5'd6, 5'd6), "forward_wb");
    end
    send(addi(5'd6, 5'd7, 16'h8001), "forward_wb");
    send(rtype(FN_SUB, 5'd2, 5'd1, 5'd3), "forward_wb");
    send(rtype(FN_SLT, 5'd5, 5'd6, 5'd7), "forward_wb");

    send(addi(5'd0, 5'd6, 16'h0007), "reg_zero");
    send(rtype(FN_ADD, 5'd0, 5'd6, 5'd7), "reg_zero");
    send(rtype(FN_OR, 5'd1, 5'd0, 5'd0), "reg_zero");
    send(rtype(FN_ADD, 5'd2, 5'd0, 5'd6), "reg_zero");

    send({6'h23, 5'd1, 5'd3, 16'h0004}, "unknown");
    send(rtype(6'd0, 5'd3, 5'd1, 5'd2), "unknown");
    send(rtype(FN_ADD, 5'd4, 5'd3, 5'd0), "unknown");

    for (int n = 0; n < 2000; n++) begin
      send(random_instr(), "random");
      r = $random(seed);
      idle(int'(r[1:0]));
    end

    drain = 0;
    while (exp_q.size() != 0 && drain < 10 * `MM_RETIRE_LATENCY) begin
      @(posedge clk);
      drain++;
    end
    if (exp_q.size() != 0) begin
      other_count++;
      $display("Error: %0d issued instructions never retired", exp_q.size());
    end
    idle(2);

    $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+source
source/mini_mips_pkg.sv
source/extract_instruction.sv
source/register_file.sv
source/main_forwarder.sv
source/pipeline_datapath.sv
source/mini_mips_top.sv
tests/mini_mips_sva.sv
tests/mini_mips_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := mini_mips_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
